//--- Makefile
TOP := capture_io_tb

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"

test:
	verilator --binary --timing --assert -f capture_io.f --top-module $(TOP) -Mdir obj_dir
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -q "Simulation finished: PASS"

clean:
	rm -rf obj_dir

//--- capture_io.f
+incdir+common
common/capture_io_pkg.sv
rtl/panel_input.sv
sys_ctrl/sys_ctrl_regs.sv
source_select/source_select.sv
rtl/capture_io_top.sv
verification/capture_io_tb.sv

//--- common/capture_io_defs.svh
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// widths, register map and control word layout of the capture I/O hub
// include wherever a width, an address or a control bit is needed
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`ifndef CAPTURE_IO_DEFS_SVH
`define CAPTURE_IO_DEFS_SVH

// cpu register port
`define REG_ADDR_W 2
`define REG_DATA_W 32

// register map
`define ADDR_SYS_CTRL   2'd0
`define ADDR_SYS_STATUS 2'd1

// control word bit positions, bit 0 is spare
`define CTRL_ISL_RESET_N_BIT    1
`define CTRL_HDMIRX_RESET_N_BIT 2
`define CTRL_CAPTURE_SEL_BIT    5
`define CTRL_ISL_VS_POL_BIT     6
`define CTRL_AUDMUX_SEL_BIT     8

// only the five decoded fields are writable (32'h166)
`define CTRL_WRITE_MASK ((32'd1 << `CTRL_ISL_RESET_N_BIT) | \
                         (32'd1 << `CTRL_HDMIRX_RESET_N_BIT) | \
                         (32'd1 << `CTRL_CAPTURE_SEL_BIT) | \
                         (32'd1 << `CTRL_ISL_VS_POL_BIT) | \
                         (32'd1 << `CTRL_AUDMUX_SEL_BIT))

// video, ir and front panel widths
`define COLOR_W  8
`define IR_CNT_W 8
`define BTN_W    2

`endif

//--- common/capture_io_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// shared types of the capture I/O hub
// import into RTL and testbench for the pixel, audio and control bundles
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
package capture_io_pkg;

`include "capture_io_defs.svh"

    // register port
    typedef logic [`REG_ADDR_W-1:0] reg_addr_t;
    typedef logic [`REG_DATA_W-1:0] reg_data_t;

    // one colour channel
    typedef logic [`COLOR_W-1:0] color_t;

    // infrared falling-edge count, wraps
    typedef logic [`IR_CNT_W-1:0] ir_cnt_t;

    // front panel buttons, active low on the board
    typedef logic [`BTN_W-1:0] btn_t;

    // one pixel beat from a capture source or to the HDMI transmitter
    typedef struct packed {
        color_t r;
        color_t g;
        color_t b;
        logic   hsync;
        logic   vsync;
        logic   de;
        // field id, only meaningful for interlaced analog input
        logic   fid;
    } video_px_t;

    // one sample of an I2S bus
    typedef struct packed {
        logic bck;
        logic ws;
        logic data;
    } i2s_t;

    // decoded fields of the system control word
    typedef struct packed {
        logic isl_reset_n;
        logic hdmirx_reset_n;
        logic capture_sel;
        logic isl_vs_pol;
        logic audmux_sel;
    } sys_ctrl_t;

endpackage

//--- rtl/capture_io_top.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// pin-level hub of the scan converter board
// connects the cpu register port, front panel and capture sources
// to the HDMI transmitter and the board control pins
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module capture_io_top
    import capture_io_pkg::*;
(
    input  logic      clk_osc,
    input  logic      po_reset_n,

    // cpu register port
    input  logic      wr_en_i,
    input  logic      rd_en_i,
    input  reg_addr_t addr_i,
    input  reg_data_t wdata_i,
    output reg_data_t rdata_o,

    // capture sources and transmitter pixel bus
    input  video_px_t isl_px_i,
    input  video_px_t hdmirx_px_i,
    output video_px_t tx_px_o,

    // audio
    input  i2s_t      pcm_i2s_i,
    input  i2s_t      hdmirx_i2s_i,
    input  logic      spdif_i,
    output i2s_t      tx_i2s_o,
    output logic      spdif_o,

    // board control pins
    output logic      isl_reset_n_o,
    output logic      hdmirx_reset_n_o,
    output logic      audmux_o,

    // front panel
    input  btn_t      btn_i,
    input  logic      ir_rx_i,
    output logic      ir_idle_led_o
);

    sys_ctrl_t ctrl;
    btn_t      btn_sync;
    ir_cnt_t   ir_cnt;

    // cpu visible control and status words
    sys_ctrl_regs u_sys_ctrl_regs (
        .clk_osc    (clk_osc),
        .po_reset_n (po_reset_n),
        .wr_en_i    (wr_en_i),
        .rd_en_i    (rd_en_i),
        .addr_i     (addr_i),
        .wdata_i    (wdata_i),
        .btn_sync_i (btn_sync),
        .ir_cnt_i   (ir_cnt),
        .rdata_o    (rdata_o),
        .ctrl_o     (ctrl)
    );

    // buttons and ir receiver
    panel_input u_panel_input (
        .clk_osc       (clk_osc),
        .po_reset_n    (po_reset_n),
        .btn_i         (btn_i),
        .ir_rx_i       (ir_rx_i),
        .btn_sync_o    (btn_sync),
        .ir_cnt_o      (ir_cnt),
        .ir_idle_led_o (ir_idle_led_o)
    );

    // video capture pipeline and audio routing
    source_select u_source_select (
        .clk_osc      (clk_osc),
        .po_reset_n   (po_reset_n),
        .ctrl_i       (ctrl),
        .isl_px_i     (isl_px_i),
        .hdmirx_px_i  (hdmirx_px_i),
        .pcm_i2s_i    (pcm_i2s_i),
        .hdmirx_i2s_i (hdmirx_i2s_i),
        .spdif_i      (spdif_i),
        .tx_px_o      (tx_px_o),
        .tx_i2s_o     (tx_i2s_o),
        .spdif_o      (spdif_o)
    );

    // chip resets and the external audio mux come straight from the control word
    assign isl_reset_n_o    = ctrl.isl_reset_n;
    assign hdmirx_reset_n_o = ctrl.hdmirx_reset_n;
    assign audmux_o         = ctrl.audmux_sel;

endmodule

//--- rtl/panel_input.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// front panel inputs
// buttons and ir line cross into clk_osc through two flops each,
// falling ir edges advance a wrapping activity count
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module panel_input
    import capture_io_pkg::*;
(
    input  logic    clk_osc,
    input  logic    po_reset_n,
    input  btn_t    btn_i,
    input  logic    ir_rx_i,
    output btn_t    btn_sync_o,
    output ir_cnt_t ir_cnt_o,
    output logic    ir_idle_led_o
);

    btn_t    btn_sync1_reg;
    btn_t    btn_sync2_reg;
    logic    ir_sync1_reg;
    logic    ir_sync2_reg;
    logic    ir_prev_reg;
    logic    ir_fall;
    ir_cnt_t ir_cnt_reg;

    // synchronizers idle high, buttons and ir receiver are active low
    always_ff @(posedge clk_osc or negedge po_reset_n) begin
        if (!po_reset_n) begin
            btn_sync1_reg <= '1;
            btn_sync2_reg <= '1;
            ir_sync1_reg  <= 1'b1;
            ir_sync2_reg  <= 1'b1;
            ir_prev_reg   <= 1'b1;
        end else begin
            btn_sync1_reg <= btn_i;
            btn_sync2_reg <= btn_sync1_reg;
            ir_sync1_reg  <= ir_rx_i;
            ir_sync2_reg  <= ir_sync1_reg;
            // third flop for edge detect
            ir_prev_reg   <= ir_sync2_reg;
        end
    end

    // high to low on the synchronized line
    assign ir_fall = ir_prev_reg & ~ir_sync2_reg;

    // activity count, wraps at full scale
    always_ff @(posedge clk_osc or negedge po_reset_n) begin
        if (!po_reset_n) begin
            ir_cnt_reg <= '0;
        end else if (ir_fall) begin
            ir_cnt_reg <= ir_cnt_reg + 1'b1;
        end
    end

    assign btn_sync_o    = btn_sync2_reg;
    assign ir_cnt_o      = ir_cnt_reg;
    // led stays lit until the first ir edge is seen
    assign ir_idle_led_o = (ir_cnt_reg == '0);

    // count steps by one only after a detected edge
    a_ir_cnt_step: assert property (@(posedge clk_osc) disable iff (!po_reset_n)
        (ir_cnt_reg != $past(ir_cnt_reg)) |->
            ($past(ir_fall) && (ir_cnt_reg == ir_cnt_t'($past(ir_cnt_reg) + 1'b1))));

endmodule

//--- source_select/source_select.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// capture source select for the HDMI transmitter
// video: two register stages, vsync polarity then source choice
// audio: one register stage, I2S source follows capture_sel
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module source_select
    import capture_io_pkg::*;
(
    input  logic      clk_osc,
    input  logic      po_reset_n,
    input  sys_ctrl_t ctrl_i,
    input  video_px_t isl_px_i,
    input  video_px_t hdmirx_px_i,
    input  i2s_t      pcm_i2s_i,
    input  i2s_t      hdmirx_i2s_i,
    input  logic      spdif_i,
    output video_px_t tx_px_o,
    output i2s_t      tx_i2s_o,
    output logic      spdif_o
);

    video_px_t isl_px_pol;
    video_px_t isl_s1_reg;
    video_px_t hdmirx_s1_reg;
    video_px_t tx_px_reg;
    i2s_t      i2s_sel;
    i2s_t      tx_i2s_reg;
    logic      spdif_reg;

    // analog vsync comes from the digitizer with either polarity
    always_comb begin
        isl_px_pol       = isl_px_i;
        isl_px_pol.vsync = isl_px_i.vsync ^ ctrl_i.isl_vs_pol;
    end

    // stage 1, both sources captured every cycle
    always_ff @(posedge clk_osc or negedge po_reset_n) begin
        if (!po_reset_n) begin
            isl_s1_reg    <= '0;
            hdmirx_s1_reg <= '0;
        end else begin
            isl_s1_reg    <= isl_px_pol;
            hdmirx_s1_reg <= hdmirx_px_i;
        end
    end

    // stage 2, select uses the control field current at this stage
    always_ff @(posedge clk_osc or negedge po_reset_n) begin
        if (!po_reset_n) begin
            tx_px_reg <= '0;
        end else if (ctrl_i.capture_sel) begin
            tx_px_reg <= hdmirx_s1_reg;
        end else begin
            tx_px_reg <= isl_s1_reg;
        end
    end

    assign tx_px_o = tx_px_reg;

    // hdmi receiver audio when capturing hdmi, external pcm otherwise
    assign i2s_sel = ctrl_i.capture_sel ? hdmirx_i2s_i : pcm_i2s_i;

    // audio out register
    always_ff @(posedge clk_osc or negedge po_reset_n) begin
        if (!po_reset_n) begin
            tx_i2s_reg <= '0;
            spdif_reg  <= 1'b0;
        end else begin
            tx_i2s_reg <= i2s_sel;
            // spdif is not switched, only retimed
            spdif_reg  <= spdif_i;
        end
    end

    assign tx_i2s_o = tx_i2s_reg;
    assign spdif_o  = spdif_reg;

    // pipeline drains reset zeros for two cycles before real pixels appear
    a_px_flush: assert property (@(posedge clk_osc)
        $rose(po_reset_n) |-> (tx_px_o == '0) ##1 (tx_px_o == '0));

endmodule

//--- sys_ctrl/sys_ctrl_regs.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// system control and status registers on the cpu port
// address 0 holds the masked control word, address 1 reads status
// read data is registered and held until the next read strobe
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`include "capture_io_defs.svh"

module sys_ctrl_regs
    import capture_io_pkg::*;
(
    input  logic      clk_osc,
    input  logic      po_reset_n,
    input  logic      wr_en_i,
    input  logic      rd_en_i,
    input  reg_addr_t addr_i,
    input  reg_data_t wdata_i,
    input  btn_t      btn_sync_i,
    input  ir_cnt_t   ir_cnt_i,
    output reg_data_t rdata_o,
    output sys_ctrl_t ctrl_o
);

    reg_data_t ctrl_word_reg;
    reg_data_t status_word;
    reg_data_t rdata_reg;

    // control word, only the decoded fields are kept
    always_ff @(posedge clk_osc or negedge po_reset_n) begin
        if (!po_reset_n) begin
            ctrl_word_reg <= '0;
        end else if (wr_en_i && (addr_i == `ADDR_SYS_CTRL)) begin
            ctrl_word_reg <= wdata_i & `CTRL_WRITE_MASK;
        end
    end

    // field decode
    assign ctrl_o.isl_reset_n    = ctrl_word_reg[`CTRL_ISL_RESET_N_BIT];
    assign ctrl_o.hdmirx_reset_n = ctrl_word_reg[`CTRL_HDMIRX_RESET_N_BIT];
    assign ctrl_o.capture_sel    = ctrl_word_reg[`CTRL_CAPTURE_SEL_BIT];
    assign ctrl_o.isl_vs_pol     = ctrl_word_reg[`CTRL_ISL_VS_POL_BIT];
    assign ctrl_o.audmux_sel     = ctrl_word_reg[`CTRL_AUDMUX_SEL_BIT];

    // status: buttons in 9:8, ir count in 7:0
    assign status_word = {{(`REG_DATA_W - `BTN_W - `IR_CNT_W){1'b0}}, btn_sync_i, ir_cnt_i};

    // read data register, unmapped addresses give zero
    always_ff @(posedge clk_osc or negedge po_reset_n) begin
        if (!po_reset_n) begin
            rdata_reg <= '0;
        end else if (rd_en_i) begin
            case (addr_i)
                `ADDR_SYS_CTRL:   rdata_reg <= ctrl_word_reg;
                `ADDR_SYS_STATUS: rdata_reg <= status_word;
                default:          rdata_reg <= '0;
            endcase
        end
    end

    assign rdata_o = rdata_reg;

    // read-only bits of the control word never get set
    a_ctrl_mask: assert property (@(posedge clk_osc) disable iff (!po_reset_n)
        (ctrl_word_reg & ~`CTRL_WRITE_MASK) == '0);

    // read data only moves as the answer to a read strobe
    a_rdata_hold: assert property (@(posedge clk_osc) disable iff (!po_reset_n)
        !$stable(rdata_o) |-> $past(rd_en_i));

endmodule

//--- verification/capture_io_tb.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// testbench of the capture I/O hub
// LFSR stimulus on every input pin and a cycle model compared at each falling edge
// runs the reset, register, video, audio and front panel phases in order
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`include "capture_io_defs.svh"

module capture_io_tb
    import capture_io_pkg::*;
();

    // phase lengths in cycles
    // the timeout allows twice their sum
    localparam int RESET_CYCLES   = 5;
    localparam int IDLE_CYCLES    = 4;
    localparam int REG_CYCLES     = 16 * 8;
    localparam int VIDEO_CYCLES   = 400;
    localparam int AUDIO_CYCLES   = 200;
    localparam int PANEL_CYCLES   = 300;
    localparam int TIMEOUT_CYCLES = 2 * (RESET_CYCLES + IDLE_CYCLES + REG_CYCLES +
                                         VIDEO_CYCLES + AUDIO_CYCLES + PANEL_CYCLES);

    logic      clk_osc;
    logic      po_reset_n;
    logic      wr_en_i;
    logic      rd_en_i;
    reg_addr_t addr_i;
    reg_data_t wdata_i;
    reg_data_t rdata_o;
    video_px_t isl_px_i;
    video_px_t hdmirx_px_i;
    video_px_t tx_px_o;
    i2s_t      pcm_i2s_i;
    i2s_t      hdmirx_i2s_i;
    i2s_t      tx_i2s_o;
    logic      spdif_i;
    logic      spdif_o;
    logic      isl_reset_n_o;
    logic      hdmirx_reset_n_o;
    logic      audmux_o;
    btn_t      btn_i;
    logic      ir_rx_i;
    logic      ir_idle_led_o;

    // values applied at the next rising edge
    logic      nxt_reset_n;
    logic      nxt_wr_en;
    logic      nxt_rd_en;
    reg_addr_t nxt_addr;
    reg_data_t nxt_wdata;
    video_px_t nxt_isl_px;
    video_px_t nxt_hdmirx_px;
    i2s_t      nxt_pcm_i2s;
    i2s_t      nxt_hdmirx_i2s;
    logic      nxt_spdif;
    btn_t      nxt_btn;
    logic      nxt_ir;

    // reference model state
    reg_data_t m_ctrl_word;
    reg_data_t m_rdata;
    video_px_t m_isl_s1;
    video_px_t m_hdmi_s1;
    video_px_t m_tx_px;
    i2s_t      m_tx_i2s;
    logic      m_spdif;
    btn_t      m_btn1;
    btn_t      m_btn2;
    logic      m_ir1;
    logic      m_ir2;
    logic      m_ir_prev;
    ir_cnt_t   m_ir_cnt;

    logic [31:0] lfsr_state;
    int          cycle_cnt;

    capture_io_top DUT (.*);

    initial begin
        clk_osc = 1'b0;
        forever #20 clk_osc = ~clk_osc;
    end

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("Simulation finished: FAIL");
        $fatal(1);
    endtask

    // run limit in rising edges
    initial begin
        cycle_cnt = 0;
        forever begin
            @(posedge clk_osc);
            cycle_cnt++;
            if (cycle_cnt >= TIMEOUT_CYCLES) begin
                abort_run("timeout: the test phases did not finish in time");
            end
        end
    end

    // x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        logic fb;
        fb = s[31] ^ s[21] ^ s[1] ^ s[0];
        return {s[30:0], fb};
    endfunction

    // one LFSR step per returned bit
    // the newest bit ends up in the lsb
    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int k = 0; k < n; k++) begin
            lfsr_state = lfsr_next(lfsr_state);
            r = {r[30:0], lfsr_state[0]};
        end
        return r;
    endfunction

    task automatic check_px(input string name, input video_px_t got, input video_px_t exp);
        if (got !== exp) begin
            $display("[ERROR] %s: got %h, expected %h", name, got, exp);
            abort_run("pixel output differs from the model");
        end
    endtask

    task automatic check_i2s(input string name, input i2s_t got, input i2s_t exp);
        if (got !== exp) begin
            $display("[ERROR] %s: got %h, expected %h", name, got, exp);
            abort_run("audio output differs from the model");
        end
    endtask

    task automatic check_word(input string name, input reg_data_t got, input reg_data_t exp);
        if (got !== exp) begin
            $display("[ERROR] %s: got %h, expected %h", name, got, exp);
            abort_run("register data differs from the expected word");
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("[ERROR] %s: got %h, expected %h", name, got, exp);
            abort_run("single bit output differs from the model");
        end
    endtask

    task automatic reset_model();
        m_ctrl_word = '0;
        m_rdata     = '0;
        m_isl_s1    = '0;
        m_hdmi_s1   = '0;
        m_tx_px     = '0;
        m_tx_i2s    = '0;
        m_spdif     = 1'b0;
        // synchronizers idle at one
        m_btn1      = '1;
        m_btn2      = '1;
        m_ir1       = 1'b1;
        m_ir2       = 1'b1;
        m_ir_prev   = 1'b1;
        m_ir_cnt    = '0;
    endtask

    // one rising edge of the model
    // inputs still hold their pre-edge values here
    task automatic update_model();
        logic cap_sel;
        logic vs_pol;
        if (!po_reset_n) begin
            reset_model();
        end else begin
            cap_sel = m_ctrl_word[`CTRL_CAPTURE_SEL_BIT];
            vs_pol  = m_ctrl_word[`CTRL_ISL_VS_POL_BIT];
            if (rd_en_i) begin
                case (addr_i)
                    `ADDR_SYS_CTRL:   m_rdata = m_ctrl_word;
                    `ADDR_SYS_STATUS: m_rdata = {22'd0, m_btn2, m_ir_cnt};
                    default:          m_rdata = '0;
                endcase
            end
            if (wr_en_i && (addr_i == `ADDR_SYS_CTRL)) begin
                m_ctrl_word = wdata_i & `CTRL_WRITE_MASK;
            end
            // stage 2 takes the stage 1 contents from before this edge
            m_tx_px        = cap_sel ? m_hdmi_s1 : m_isl_s1;
            m_hdmi_s1      = hdmirx_px_i;
            m_isl_s1       = isl_px_i;
            m_isl_s1.vsync = isl_px_i.vsync ^ vs_pol;
            m_tx_i2s       = cap_sel ? hdmirx_i2s_i : pcm_i2s_i;
            m_spdif        = spdif_i;
            if (m_ir_prev && !m_ir2) begin
                m_ir_cnt = m_ir_cnt + 8'd1;
            end
            m_ir_prev = m_ir2;
            m_ir2     = m_ir1;
            m_ir1     = ir_rx_i;
            m_btn2    = m_btn1;
            m_btn1    = btn_i;
        end
    endtask

    task automatic check_outputs();
        check_word("rdata_o", rdata_o, m_rdata);
        check_px("tx_px_o", tx_px_o, m_tx_px);
        check_i2s("tx_i2s_o", tx_i2s_o, m_tx_i2s);
        check_bit("spdif_o", spdif_o, m_spdif);
        check_bit("isl_reset_n_o", isl_reset_n_o, m_ctrl_word[`CTRL_ISL_RESET_N_BIT]);
        check_bit("hdmirx_reset_n_o", hdmirx_reset_n_o, m_ctrl_word[`CTRL_HDMIRX_RESET_N_BIT]);
        check_bit("audmux_o", audmux_o, m_ctrl_word[`CTRL_AUDMUX_SEL_BIT]);
        check_bit("ir_idle_led_o", ir_idle_led_o, m_ir_cnt == '0);
    endtask

    // model and drive on the rising edge and compare on the falling edge
    task automatic run_cycle();
        @(posedge clk_osc);
        update_model();
        po_reset_n   <= nxt_reset_n;
        wr_en_i      <= nxt_wr_en;
        rd_en_i      <= nxt_rd_en;
        addr_i       <= nxt_addr;
        wdata_i      <= nxt_wdata;
        isl_px_i     <= nxt_isl_px;
        hdmirx_px_i  <= nxt_hdmirx_px;
        pcm_i2s_i    <= nxt_pcm_i2s;
        hdmirx_i2s_i <= nxt_hdmirx_i2s;
        spdif_i      <= nxt_spdif;
        btn_i        <= nxt_btn;
        ir_rx_i      <= nxt_ir;
        @(negedge clk_osc);
        check_outputs();
    endtask

    task automatic write_reg(input reg_addr_t addr, input reg_data_t data);
        nxt_wr_en = 1'b1;
        nxt_addr  = addr;
        nxt_wdata = data;
        run_cycle();
        nxt_wr_en = 1'b0;
    endtask

    // strobe and wait one more cycle until rdata_o holds the answer
    task automatic read_reg(input reg_addr_t addr);
        nxt_rd_en = 1'b1;
        nxt_addr  = addr;
        run_cycle();
        nxt_rd_en = 1'b0;
        run_cycle();
    endtask

    initial begin
        reg_data_t   word;
        reg_data_t   kept;
        logic [31:0] bits;
        reg_addr_t   other;
        lfsr_state = 32'hecd7_bfe1;
        po_reset_n = 1'b0;
        wr_en_i = 1'b0;
        rd_en_i = 1'b0;
        addr_i = '0;
        wdata_i = '0;
        isl_px_i = '0;
        hdmirx_px_i = '0;
        pcm_i2s_i = '0;
        hdmirx_i2s_i = '0;
        spdif_i = 1'b0;
        btn_i = '1;
        ir_rx_i = 1'b1;
        nxt_reset_n = 1'b0;
        nxt_wr_en = 1'b0;
        nxt_rd_en = 1'b0;
        nxt_addr = '0;
        nxt_wdata = '0;
        // random source data is already present while reset is held
        bits = take_bits($bits(video_px_t));
        nxt_isl_px = bits[$bits(video_px_t)-1:0];
        bits = take_bits($bits(video_px_t));
        nxt_hdmirx_px = bits[$bits(video_px_t)-1:0];
        bits = take_bits(3);
        nxt_pcm_i2s = bits[2:0];
        bits = take_bits(3);
        nxt_hdmirx_i2s = bits[2:0];
        bits = take_bits(1);
        nxt_spdif = bits[0];
        nxt_btn = '1;
        nxt_ir = 1'b1;
        reset_model();

        // reset stays low for four edges before the release edge
        repeat (RESET_CYCLES - 1) run_cycle();
        nxt_reset_n = 1'b1;
        run_cycle();

        // state right after reset
        check_bit("isl_reset_n_o", isl_reset_n_o, 1'b0);
        check_bit("hdmirx_reset_n_o", hdmirx_reset_n_o, 1'b0);
        check_bit("audmux_o", audmux_o, 1'b0);
        check_bit("ir_idle_led_o", ir_idle_led_o, 1'b1);
        check_px("tx_px_o", tx_px_o, '0);
        read_reg(`ADDR_SYS_CTRL);
        check_word("rdata_o", rdata_o, 32'h0000_0000);
        read_reg(`ADDR_SYS_STATUS);
        check_word("rdata_o", rdata_o, 32'h0000_0300);

        // register access
        for (int i = 0; i < 16; i++) begin
            word = take_bits(32);
            write_reg(`ADDR_SYS_CTRL, word);
            read_reg(`ADDR_SYS_CTRL);
            kept = word & `CTRL_WRITE_MASK;
            check_word("rdata_o", rdata_o, kept);
            bits  = take_bits(2);
            other = bits[1:0];
            if (other == `ADDR_SYS_CTRL) begin
                other = `ADDR_SYS_STATUS;
            end
            write_reg(other, take_bits(32));
            read_reg(`ADDR_SYS_CTRL);
            check_word("rdata_o", rdata_o, kept);
            read_reg(take_bits(1) ? 2'd3 : 2'd2);
            check_word("rdata_o", rdata_o, 32'h0000_0000);
        end

        // video with occasional writes that flip capture_sel and isl_vs_pol
        for (int i = 0; i < VIDEO_CYCLES; i++) begin
            bits          = take_bits($bits(video_px_t));
            nxt_isl_px    = bits[$bits(video_px_t)-1:0];
            bits          = take_bits($bits(video_px_t));
            nxt_hdmirx_px = bits[$bits(video_px_t)-1:0];
            if (take_bits(3) == 32'd0) begin
                nxt_wr_en = 1'b1;
                nxt_addr  = `ADDR_SYS_CTRL;
                nxt_wdata = take_bits(32);
            end
            run_cycle();
            nxt_wr_en = 1'b0;
        end

        // audio from the pcm source first and then from the hdmi receiver
        for (int i = 0; i < AUDIO_CYCLES; i++) begin
            bits           = take_bits(3);
            nxt_pcm_i2s    = bits[2:0];
            bits           = take_bits(3);
            nxt_hdmirx_i2s = bits[2:0];
            bits           = take_bits(1);
            nxt_spdif      = bits[0];
            if (i == 0 || i == AUDIO_CYCLES / 2) begin
                nxt_wr_en = 1'b1;
                nxt_addr  = `ADDR_SYS_CTRL;
                nxt_wdata = (i == 0) ? 32'h0000_0000 : (32'd1 << `CTRL_CAPTURE_SEL_BIT);
            end
            run_cycle();
            nxt_wr_en = 1'b0;
        end

        // front panel with a status read every 16 cycles
        for (int i = 0; i < PANEL_CYCLES; i++) begin
            bits    = take_bits(2);
            nxt_btn = bits[1:0];
            bits    = take_bits(1);
            nxt_ir  = bits[0];
            if ((i % 16) == 0) begin
                nxt_rd_en = 1'b1;
                nxt_addr  = `ADDR_SYS_STATUS;
            end
            run_cycle();
            nxt_rd_en = 1'b0;
        end

        $display("Simulation finished: PASS");
        $finish;
    end

endmodule
